/* bench/mesh_pod_sva.sv */
`default_nettype none

`include "mesh_params.svh"

module mesh_pod_sva
  import mesh_pkg::*;
(
  input logic         clk_i,
  input logic         arst_n_i,
  input logic         host_req_ready_o,
  input logic         host_resp_v_o,
  input mesh_packet_t host_resp_o,
  input logic         host_resp_ready_i
);

  int fail_count = 0;

  // Host port idle while reset is held
  reset_idle: assert property (@(posedge clk_i)
    !arst_n_i |-> (!host_resp_v_o && host_req_ready_o))
    else
    begin
      $error("host port not idle during reset");
      fail_count++;
    end

  // A stalled reply stays put until taken
  resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (host_resp_v_o && !host_resp_ready_i) |=> (host_resp_v_o && $stable(host_resp_o)))
    else
    begin
      $error("reply changed or vanished while stalled");
      fail_count++;
    end

  resp_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_resp_v_o |-> (host_resp_o.op == e_op_reply))
    else
    begin
      $error("reply packet without reply opcode");
      fail_count++;
    end

endmodule

bind mesh_pod mesh_pod_sva sva_i (.*);

`default_nettype wire

/* bench/mesh_pod_tb.sv */
`default_nettype none

`include "mesh_params.svh"

module mesh_pod_tb
  import mesh_pkg::*;
();

  localparam int TX = `MESH_TILES_X;
  localparam int TY = `MESH_TILES_Y;
  localparam int NUM_TILES = TX * TY;
  localparam int WORDS = 2 ** `MESH_ADDR_W;
  localparam int N_BURST = 24;
  localparam int TOTAL_REQS = NUM_TILES + 2 * NUM_TILES + 400 + 200 + 2 * N_BURST;

  logic         clk;
  logic         arst_n;
  logic         host_req_v_i;
  mesh_packet_t host_req_i;
  logic         host_req_ready_o;
  logic         host_resp_v_o;
  mesh_packet_t host_resp_o;
  logic         host_resp_ready_i;

  integer                  seed = 58;
  integer                  ready_seed = 58;
  int                      error_count = 0;
  int                      tests_ok = 0;
  int                      tests_bad = 0;
  int                      src_switches = 0;
  logic                    bp_on = 1'b0;
  logic [3:0]              last_src = '0;
  logic [`MESH_DATA_W-1:0] model_mem [NUM_TILES][WORDS];
  mesh_packet_t            exp_q [NUM_TILES][$];

  mesh_pod mesh_pod_i
  (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .host_req_v_i      (host_req_v_i),
    .host_req_i        (host_req_i),
    .host_req_ready_o  (host_req_ready_o),
    .host_resp_v_o     (host_resp_v_o),
    .host_resp_o       (host_resp_o),
    .host_resp_ready_i (host_resp_ready_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (TOTAL_REQS * 200) @(posedge clk);
    $display("watchdog expired before the traffic drained");
    $display("Test failed");
    $finish;
  end

  task automatic compare_packet(input mesh_packet_t got, input mesh_packet_t exp,
                                input string name);
    if (got !== exp)
    begin
      $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_op(input mesh_op_e got, input mesh_op_e exp, input string name);
    if (got !== exp)
    begin
      $display("error t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      error_count++;
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  // Testbench checks plus bound assertion failures
  function automatic int total_errors();
    return error_count + mesh_pod_i.sva_i.fail_count;
  endfunction

  function automatic int tile_index(input int x, input int y);
    return (y - 1) * TX + x;
  endfunction

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int t = 0; t < NUM_TILES; t++)
      if (exp_q[t].size() != 0)
        empty = 1'b0;
    return empty;
  endfunction

  // Response ready toggles at random while back-pressure is on
  always @(negedge clk)
    host_resp_ready_i = bp_on ? (($random(ready_seed) & 1) != 0) : 1'b1;

  task automatic check_reply(input mesh_packet_t got);
    int           t;
    mesh_packet_t exp;
    if (got.src_y < 1 || got.src_y > TY || got.src_x >= TX)
    begin
      $display("reply at t=%0t came from a node with no tile", $time);
      error_count++;
      return;
    end
    t = tile_index(got.src_x, got.src_y);
    if ({got.src_x, got.src_y} != last_src)
      src_switches++;
    last_src = {got.src_x, got.src_y};
    if (exp_q[t].size() == 0)
    begin
      $display("reply arrived with no request outstanding for tile %0d at t=%0t", t, $time);
      error_count++;
      return;
    end
    exp = exp_q[t].pop_front();
    compare_op(got.op, e_op_reply, "host_resp_o.op");
    compare_packet(got, exp, "host_resp_o");
  endtask

  always @(posedge clk)
  begin
    if (arst_n && host_resp_v_o && host_resp_ready_i)
      check_reply(host_resp_o);
  end

  // Reply is predicted from the model when the request is accepted
  task automatic send_request(input mesh_op_e op, input int x, input int y,
                              input logic [`MESH_ADDR_W-1:0] addr,
                              input logic [`MESH_DATA_W-1:0] data);
    int           t;
    mesh_packet_t pkt;
    mesh_packet_t exp;
    t          = tile_index(x, y);
    pkt.op     = op;
    pkt.dest_x = `MESH_X_W'(x);
    pkt.dest_y = `MESH_Y_W'(y);
    pkt.src_x  = '0;
    pkt.src_y  = '0;
    pkt.addr   = addr;
    pkt.data   = data;
    @(negedge clk);
    host_req_v_i = 1'b1;
    host_req_i   = pkt;
    do
      @(posedge clk);
    while (!host_req_ready_o);
    exp        = pkt;
    exp.op     = e_op_reply;
    exp.dest_x = '0;
    exp.dest_y = '0;
    exp.src_x  = `MESH_X_W'(x);
    exp.src_y  = `MESH_Y_W'(y);
    if (op == e_op_store)
      model_mem[t][addr] = data;
    else
      exp.data = model_mem[t][addr];
    exp_q[t].push_back(exp);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      host_req_v_i = 1'b0;
    end
  endtask

  task automatic random_request(input int x, input int y);
    mesh_op_e op;
    op = (($random(seed) & 1) != 0) ? e_op_store : e_op_load;
    send_request(op, x, y, `MESH_ADDR_W'($random(seed)), $random(seed));
  endtask

  task automatic random_traffic(input int n, input int gap_max);
    for (int i = 0; i < n; i++)
    begin
      random_request({$random(seed)} % TX, 1 + {$random(seed)} % TY);
      idle_cycles({$random(seed)} % (gap_max + 1));
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    while (!queues_empty())
      @(posedge clk);
    repeat (10) @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs_now;
    errs_now = total_errors();
    if (errs_now == errs_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs_now - errs_before);
    end
  endtask

  initial
  begin
    int                      errs;
    logic [`MESH_ADDR_W-1:0] addr;
    arst_n       = 1'b1;
    host_req_v_i = 1'b0;
    host_req_i   = '0;
    bp_on        = 1'b0;
    host_resp_ready_i = 1'b1;
    for (int t = 0; t < NUM_TILES; t++)
      for (int w = 0; w < WORDS; w++)
        model_mem[t][w] = '0;
    #1;
    arst_n = 1'b0;

    errs = total_errors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    compare_bit(host_resp_v_o, 1'b0, "host_resp_v_o");
    compare_bit(host_req_ready_o, 1'b1, "host_req_ready_o");
    arst_n = 1'b1;
    @(negedge clk);
    compare_bit(host_resp_v_o, 1'b0, "host_resp_v_o");
    compare_bit(host_req_ready_o, 1'b1, "host_req_ready_o");
    for (int y = 1; y <= TY; y++)
      for (int x = 0; x < TX; x++)
        send_request(e_op_load, x, y, `MESH_ADDR_W'($random(seed)), '0);
    wait_drain();
    finish_test("reset", errs);

    errs = total_errors();
    for (int y = 1; y <= TY; y++)
      for (int x = 0; x < TX; x++)
      begin
        addr = `MESH_ADDR_W'($random(seed));
        send_request(e_op_store, x, y, addr, $random(seed));
        send_request(e_op_load, x, y, addr, '0);
      end
    wait_drain();
    finish_test("store_load", errs);

    errs = total_errors();
    random_traffic(400, 3);
    wait_drain();
    finish_test("random", errs);

    errs = total_errors();
    bp_on = 1'b1;
    random_traffic(200, 2);
    bp_on = 1'b0;
    wait_drain();
    finish_test("backpressure", errs);

    // Far and near tile streams share the column 0 routers
    errs = total_errors();
    src_switches = 0;
    for (int i = 0; i < N_BURST; i++)
    begin
      random_request(1, 2);
      random_request(0, 1);
    end
    wait_drain();
    // Two back-to-back blocks give at most two source changes
    if (src_switches < 3)
    begin
      $display("replies from the two burst tiles did not interleave");
      error_count++;
    end
    finish_test("burst", errs);

    $display("%0d tests ok, %0d tests with errors, %0d failed checks",
             tests_ok, tests_bad, total_errors());
    if (total_errors() == 0 && tests_bad == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/mesh_params.svh */
`ifndef MESH_PARAMS_SVH
`define MESH_PARAMS_SVH

// Tile array, IO row has one router per column
`define MESH_TILES_X 2
`define MESH_TILES_Y 2

// Coordinate widths cover y = 0..MESH_TILES_Y
`define MESH_X_W 2
`define MESH_Y_W 2

// Scratchpad word address and data word
`define MESH_ADDR_W 6
`define MESH_DATA_W 32

// Entries per router input FIFO
`define MESH_FIFO_ELS 2

`endif

/* logic/mesh_pkg.sv */
`default_nettype none

`include "mesh_params.svh"

package mesh_pkg;

  typedef enum logic [1:0]
  {
    e_op_load  = 2'd0,
    e_op_store = 2'd1,
    e_op_reply = 2'd2
  } mesh_op_e;

  // Router ports, P must stay at index 0
  typedef enum logic [2:0]
  {
    e_dir_p = 3'd0,
    e_dir_w = 3'd1,
    e_dir_e = 3'd2,
    e_dir_n = 3'd3,
    e_dir_s = 3'd4
  } mesh_dir_e;

  typedef struct packed
  {
    mesh_op_e                op;
    logic [`MESH_X_W-1:0]    dest_x;
    logic [`MESH_Y_W-1:0]    dest_y;
    logic [`MESH_X_W-1:0]    src_x;
    logic [`MESH_Y_W-1:0]    src_y;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } mesh_packet_t;

endpackage

`default_nettype wire

/* logic/mesh_pod.sv */
`default_nettype none

`include "mesh_params.svh"

module mesh_pod
  import mesh_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,

  input  logic         host_req_v_i,
  input  mesh_packet_t host_req_i,
  output logic         host_req_ready_o,

  output logic         host_resp_v_o,
  output mesh_packet_t host_resp_o,
  input  logic         host_resp_ready_i
);

  localparam int TX = `MESH_TILES_X;
  localparam int TY = `MESH_TILES_Y;
  localparam int NET_FWD = 0;
  localparam int NET_REV = 1;

  // Per network, per node, per port. Row 0 is the IO row
  wire logic         [1:0][TY:0][TX-1:0][4:0] v_li;
  wire mesh_packet_t [1:0][TY:0][TX-1:0][4:0] pkt_li;
  wire logic         [1:0][TY:0][TX-1:0][4:0] ready_lo;
  wire logic         [1:0][TY:0][TX-1:0][4:0] v_lo;
  wire mesh_packet_t [1:0][TY:0][TX-1:0][4:0] pkt_lo;
  wire logic         [1:0][TY:0][TX-1:0][4:0] ready_li;

  for (genvar y = 0; y <= TY; y++)
  begin : row
    for (genvar x = 0; x < TX; x++)
    begin : col
      for (genvar n = 0; n < 2; n++)
      begin : net
        if (x > 0)
        begin : w_link
          assign v_li[n][y][x][e_dir_w]     = v_lo[n][y][x-1][e_dir_e];
          assign pkt_li[n][y][x][e_dir_w]   = pkt_lo[n][y][x-1][e_dir_e];
          assign ready_li[n][y][x][e_dir_w] = ready_lo[n][y][x-1][e_dir_e];
        end
        else
        begin : w_edge
          assign v_li[n][y][x][e_dir_w]     = 1'b0;
          assign pkt_li[n][y][x][e_dir_w]   = '0;
          assign ready_li[n][y][x][e_dir_w] = 1'b1;
        end

        if (x < TX - 1)
        begin : e_link
          assign v_li[n][y][x][e_dir_e]     = v_lo[n][y][x+1][e_dir_w];
          assign pkt_li[n][y][x][e_dir_e]   = pkt_lo[n][y][x+1][e_dir_w];
          assign ready_li[n][y][x][e_dir_e] = ready_lo[n][y][x+1][e_dir_w];
        end
        else
        begin : e_edge
          assign v_li[n][y][x][e_dir_e]     = 1'b0;
          assign pkt_li[n][y][x][e_dir_e]   = '0;
          assign ready_li[n][y][x][e_dir_e] = 1'b1;
        end

        if (y > 0)
        begin : n_link
          assign v_li[n][y][x][e_dir_n]     = v_lo[n][y-1][x][e_dir_s];
          assign pkt_li[n][y][x][e_dir_n]   = pkt_lo[n][y-1][x][e_dir_s];
          assign ready_li[n][y][x][e_dir_n] = ready_lo[n][y-1][x][e_dir_s];
        end
        else
        begin : n_edge
          assign v_li[n][y][x][e_dir_n]     = 1'b0;
          assign pkt_li[n][y][x][e_dir_n]   = '0;
          assign ready_li[n][y][x][e_dir_n] = 1'b1;
        end

        if (y < TY)
        begin : s_link
          assign v_li[n][y][x][e_dir_s]     = v_lo[n][y+1][x][e_dir_n];
          assign pkt_li[n][y][x][e_dir_s]   = pkt_lo[n][y+1][x][e_dir_n];
          assign ready_li[n][y][x][e_dir_s] = ready_lo[n][y+1][x][e_dir_n];
        end
        else
        begin : s_edge
          assign v_li[n][y][x][e_dir_s]     = 1'b0;
          assign pkt_li[n][y][x][e_dir_s]   = '0;
          assign ready_li[n][y][x][e_dir_s] = 1'b1;
        end

        if (y == 0)
        begin : io_rtr
          mesh_router #(.MY_X(x), .MY_Y(0)) rtr
          (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .link_v_i     (v_li[n][y][x]),
            .link_pkt_i   (pkt_li[n][y][x]),
            .link_ready_o (ready_lo[n][y][x]),
            .link_v_o     (v_lo[n][y][x]),
            .link_pkt_o   (pkt_lo[n][y][x]),
            .link_ready_i (ready_li[n][y][x])
          );

          // Only the host port at x=0 is live
          if (x > 0)
          begin : p_tieoff
            assign v_li[n][y][x][e_dir_p]     = 1'b0;
            assign pkt_li[n][y][x][e_dir_p]   = '0;
            assign ready_li[n][y][x][e_dir_p] = 1'b1;
          end
        end
      end

      if (y > 0)
      begin : tile
        scratch_tile #(.MY_X(x), .MY_Y(y)) st
        (
          .clk_i       (clk_i),
          .arst_n_i    (arst_n_i),
          .fwd_v_i     (v_li[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .fwd_pkt_i   (pkt_li[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .fwd_ready_o (ready_lo[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .fwd_v_o     (v_lo[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .fwd_pkt_o   (pkt_lo[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .fwd_ready_i (ready_li[NET_FWD][y][x][e_dir_s:e_dir_w]),
          .rev_v_i     (v_li[NET_REV][y][x][e_dir_s:e_dir_w]),
          .rev_pkt_i   (pkt_li[NET_REV][y][x][e_dir_s:e_dir_w]),
          .rev_ready_o (ready_lo[NET_REV][y][x][e_dir_s:e_dir_w]),
          .rev_v_o     (v_lo[NET_REV][y][x][e_dir_s:e_dir_w]),
          .rev_pkt_o   (pkt_lo[NET_REV][y][x][e_dir_s:e_dir_w]),
          .rev_ready_i (ready_li[NET_REV][y][x][e_dir_s:e_dir_w])
        );
      end
    end
  end

  // Host requests enter the forward network at (0,0)
  assign v_li[NET_FWD][0][0][e_dir_p]     = host_req_v_i;
  assign pkt_li[NET_FWD][0][0][e_dir_p]   = host_req_i;
  assign host_req_ready_o                 = ready_lo[NET_FWD][0][0][e_dir_p];
  assign ready_li[NET_FWD][0][0][e_dir_p] = 1'b1;

  // Replies leave the reverse network at (0,0)
  assign v_li[NET_REV][0][0][e_dir_p]     = 1'b0;
  assign pkt_li[NET_REV][0][0][e_dir_p]   = '0;
  assign host_resp_v_o                    = v_lo[NET_REV][0][0][e_dir_p];
  assign host_resp_o                      = pkt_lo[NET_REV][0][0][e_dir_p];
  assign ready_li[NET_REV][0][0][e_dir_p] = host_resp_ready_i;

endmodule

`default_nettype wire

/* logic/mesh_router.sv */
`default_nettype none

`include "mesh_params.svh"

module mesh_router
  import mesh_pkg::*;
#(
  parameter int MY_X = 0,
  parameter int MY_Y = 0
)
(
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic         [4:0] link_v_i,
  input  mesh_packet_t [4:0] link_pkt_i,
  output logic         [4:0] link_ready_o,

  output logic         [4:0] link_v_o,
  output mesh_packet_t [4:0] link_pkt_o,
  input  logic         [4:0] link_ready_i
);

  localparam int NUM_PORTS = 5;
  localparam int FIFO_ELS = `MESH_FIFO_ELS;
  localparam int PTR_W = (FIFO_ELS > 1) ? $clog2(FIFO_ELS) : 1;
  localparam int CNT_W = $clog2(FIFO_ELS + 1);

  localparam logic [`MESH_X_W-1:0] MY_X_C = `MESH_X_W'(MY_X);
  localparam logic [`MESH_Y_W-1:0] MY_Y_C = `MESH_Y_W'(MY_Y);

  logic         [NUM_PORTS-1:0]                head_v;
  mesh_packet_t [NUM_PORTS-1:0]                head_pkt;
  mesh_dir_e                                   route [NUM_PORTS];
  logic         [NUM_PORTS-1:0][NUM_PORTS-1:0] req;
  logic         [NUM_PORTS-1:0][2:0]           grant;
  logic         [NUM_PORTS-1:0]                xfer;
  logic         [NUM_PORTS-1:0]                pop_v;

  // First requester at or after the priority pointer
  function automatic logic [2:0] rr_pick(input logic [NUM_PORTS-1:0] req_i,
                                         input logic [2:0] ptr_i);
    logic [2:0] idx;
    logic [2:0] pick;
    logic       found;
    pick  = ptr_i;
    found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      idx = 3'((int'(ptr_i) + k) % NUM_PORTS);
      if (!found && req_i[idx])
      begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : in_fifo
    mesh_packet_t     mem [FIFO_ELS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;

    assign push            = link_v_i[i] && link_ready_o[i];
    assign link_ready_o[i] = (count_q < CNT_W'(FIFO_ELS));
    assign head_v[i]       = (count_q != '0);
    assign head_pkt[i]     = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end
      else
      begin
        if (push)
          wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_ELS - 1)) ? '0 : wr_ptr_q + 1'b1;
        if (pop_v[i])
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_ELS - 1)) ? '0 : rd_ptr_q + 1'b1;
        if (push && !pop_v[i])
          count_q <= count_q + 1'b1;
        else if (!push && pop_v[i])
          count_q <= count_q - 1'b1;
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (push)
        mem[wr_ptr_q] <= link_pkt_i[i];
    end
  end

  // XY routing of each FIFO head
  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (head_pkt[i].dest_x > MY_X_C)
        route[i] = e_dir_e;
      else if (head_pkt[i].dest_x < MY_X_C)
        route[i] = e_dir_w;
      else if (head_pkt[i].dest_y > MY_Y_C)
        route[i] = e_dir_s;
      else if (head_pkt[i].dest_y < MY_Y_C)
        route[i] = e_dir_n;
      else
        route[i] = e_dir_p;
    end
  end

  always_comb
  begin
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      for (int i = 0; i < NUM_PORTS; i++)
        req[o][i] = head_v[i] && (route[i] == mesh_dir_e'(o));
    end
  end

  // Each head requests one output, so at most one pop per input
  always_comb
  begin
    pop_v = '0;
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      if (xfer[o])
        pop_v[grant[o]] = 1'b1;
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++)
  begin : out_arb
    logic [2:0] rr_ptr_q;
    logic [2:0] hold_idx_q;
    logic       hold_q;

    // A stalled output keeps its winner so the packet stays stable
    assign grant[o]      = hold_q ? hold_idx_q : rr_pick(req[o], rr_ptr_q);
    assign link_v_o[o]   = |req[o];
    assign link_pkt_o[o] = head_pkt[grant[o]];
    assign xfer[o]       = link_v_o[o] && link_ready_i[o];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        rr_ptr_q   <= '0;
        hold_idx_q <= '0;
        hold_q     <= 1'b0;
      end
      else
      begin
        hold_q     <= link_v_o[o] && !link_ready_i[o];
        hold_idx_q <= grant[o];
        if (xfer[o])
          rr_ptr_q <= (grant[o] == 3'(NUM_PORTS - 1)) ? 3'd0 : grant[o] + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/scratch_tile.sv */
`default_nettype none

`include "mesh_params.svh"

module scratch_tile
  import mesh_pkg::*;
#(
  parameter int MY_X = 0,
  parameter int MY_Y = 1
)
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  logic         [e_dir_s:e_dir_w]   fwd_v_i,
  input  mesh_packet_t [e_dir_s:e_dir_w]   fwd_pkt_i,
  output logic         [e_dir_s:e_dir_w]   fwd_ready_o,
  output logic         [e_dir_s:e_dir_w]   fwd_v_o,
  output mesh_packet_t [e_dir_s:e_dir_w]   fwd_pkt_o,
  input  logic         [e_dir_s:e_dir_w]   fwd_ready_i,

  input  logic         [e_dir_s:e_dir_w]   rev_v_i,
  input  mesh_packet_t [e_dir_s:e_dir_w]   rev_pkt_i,
  output logic         [e_dir_s:e_dir_w]   rev_ready_o,
  output logic         [e_dir_s:e_dir_w]   rev_v_o,
  output mesh_packet_t [e_dir_s:e_dir_w]   rev_pkt_o,
  input  logic         [e_dir_s:e_dir_w]   rev_ready_i
);

  localparam int WORDS = 2 ** `MESH_ADDR_W;

  logic         [4:0] fwd_v_li, fwd_ready_lo, fwd_v_lo, fwd_ready_li;
  mesh_packet_t [4:0] fwd_pkt_li, fwd_pkt_lo;
  logic         [4:0] rev_v_li, rev_ready_lo, rev_v_lo, rev_ready_li;
  mesh_packet_t [4:0] rev_pkt_li, rev_pkt_lo;

  logic [`MESH_DATA_W-1:0] mem_q [WORDS];
  logic                    resp_v_q;
  mesh_packet_t            resp_pkt_q;
  logic                    ep_ready;
  logic                    ep_accept;
  mesh_packet_t            req_pkt;

  // P sits at index 0 below the four mesh ports
  assign fwd_v_li     = {fwd_v_i, 1'b0};
  assign fwd_pkt_li   = {fwd_pkt_i, mesh_packet_t'(0)};
  assign fwd_ready_li = {fwd_ready_i, ep_ready};
  assign fwd_ready_o  = fwd_ready_lo[e_dir_s:e_dir_w];
  assign fwd_v_o      = fwd_v_lo[e_dir_s:e_dir_w];
  assign fwd_pkt_o    = fwd_pkt_lo[e_dir_s:e_dir_w];

  assign rev_v_li     = {rev_v_i, resp_v_q};
  assign rev_pkt_li   = {rev_pkt_i, resp_pkt_q};
  assign rev_ready_li = {rev_ready_i, 1'b1};
  assign rev_ready_o  = rev_ready_lo[e_dir_s:e_dir_w];
  assign rev_v_o      = rev_v_lo[e_dir_s:e_dir_w];
  assign rev_pkt_o    = rev_pkt_lo[e_dir_s:e_dir_w];

  mesh_router #(.MY_X(MY_X), .MY_Y(MY_Y)) fwd_rtr
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_v_i     (fwd_v_li),
    .link_pkt_i   (fwd_pkt_li),
    .link_ready_o (fwd_ready_lo),
    .link_v_o     (fwd_v_lo),
    .link_pkt_o   (fwd_pkt_lo),
    .link_ready_i (fwd_ready_li)
  );

  mesh_router #(.MY_X(MY_X), .MY_Y(MY_Y)) rev_rtr
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_v_i     (rev_v_li),
    .link_pkt_i   (rev_pkt_li),
    .link_ready_o (rev_ready_lo),
    .link_v_o     (rev_v_lo),
    .link_pkt_o   (rev_pkt_lo),
    .link_ready_i (rev_ready_li)
  );

  // Take a request only if the reply slot frees up this cycle
  assign ep_ready  = !resp_v_q || rev_ready_lo[e_dir_p];
  assign ep_accept = fwd_v_lo[e_dir_p] && ep_ready;
  assign req_pkt   = fwd_pkt_lo[e_dir_p];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_q <= 1'b0;
      for (int w = 0; w < WORDS; w++)
        mem_q[w] <= '0;
    end
    else
    begin
      if (ep_accept)
        resp_v_q <= 1'b1;
      else if (rev_ready_lo[e_dir_p])
        resp_v_q <= 1'b0;
      if (ep_accept && (req_pkt.op == e_op_store))
        mem_q[req_pkt.addr] <= req_pkt.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ep_accept)
    begin
      resp_pkt_q.op     <= e_op_reply;
      resp_pkt_q.dest_x <= req_pkt.src_x;
      resp_pkt_q.dest_y <= req_pkt.src_y;
      resp_pkt_q.src_x  <= `MESH_X_W'(MY_X);
      resp_pkt_q.src_y  <= `MESH_Y_W'(MY_Y);
      resp_pkt_q.addr   <= req_pkt.addr;
      resp_pkt_q.data   <= (req_pkt.op == e_op_store) ? req_pkt.data : mem_q[req_pkt.addr];
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/mesh_pkg.sv
logic/mesh_router.sv
logic/scratch_tile.sv
logic/mesh_pod.sv
bench/mesh_pod_sva.sv
bench/mesh_pod_tb.sv
